//--- src/wb_pkg.sv
package wb_pkg;

    // result slots carried by one instruction record
    localparam int num_slots = 4;

    // architectural register counts
    localparam int num_gpr = 8;
    localparam int num_seg = 6;

    localparam int eflags_w = 18;

    // memory byte enables for each operand size
    localparam logic [3:0] be_byte  = 4'b0001;
    localparam logic [3:0] be_word  = 4'b0011;
    localparam logic [3:0] be_dword = 4'b1111;

    typedef enum logic [1:0] {
        kind_none = 2'd0,
        kind_gpr  = 2'd1,
        kind_seg  = 2'd2,
        kind_mem  = 2'd3
    } res_kind_e;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } res_size_e;

    typedef struct packed {
        logic [28:0] pad;
        logic [2:0]  idx;
    } reg_dest_t;

    // the same destination word is a register index or a byte address,
    // depending on the result kind
    typedef union packed {
        reg_dest_t   regv;
        logic [31:0] addr;
    } wb_dest_u;

    typedef struct packed {
        logic        wr;
        res_kind_e   kind;
        wb_dest_u    dest;
        logic [31:0] data;
    } wb_result_t;

    typedef struct packed {
        logic                                valid;
        logic [31:0]                         eip;
        logic                                ie;
        logic [3:0]                          ie_type;
        logic [eflags_w-1:0]                 eflags;
        res_size_e                           size;
        wb_result_t [num_slots-1:0]          results;
        logic                                br_valid;
        logic                                br_taken;
        logic                                br_pred_taken;
        logic [31:0]                         br_pred_target;
        logic [31:0]                         br_fip;
        logic [31:0]                         br_fip_p1;
    } ex_wb_t;

    // gpr data is already merged with the untouched upper bits
    typedef struct packed {
        logic        en;
        logic [2:0]  idx;
        logic [31:0] data;
    } gpr_wr_t;

    typedef struct packed {
        logic        en;
        logic [2:0]  idx;
        logic [15:0] data;
    } seg_wr_t;

    typedef struct packed {
        logic        en;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
    } mem_wr_t;

    typedef struct packed {
        logic        valid;
        logic [3:0]  ie_type;
        logic [31:0] eip;
    } exc_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

//--- src/ex_wb_latch.sv
`timescale 1ns/1ps

module ex_wb_latch (
    input  logic           clk,
    input  logic           arst_n,
    input  wb_pkg::ex_wb_t ex,
    input  logic           flush,
    input  logic           redirect_valid,
    output wb_pkg::ex_wb_t wb
);

    logic squash;

    // a redirect from writeback kills the younger record entering this edge
    assign squash = flush || redirect_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else begin
            wb <= ex;
            if (squash) begin
                wb.valid <= 1'b0;
            end
        end
    end

    // a squashed record must never reach writeback as valid
    a_squash_clears_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        squash |=> !wb.valid
    ) else $error("ex_wb_latch: squashed record still valid");

endmodule

//--- src/wb_commit.sv
`timescale 1ns/1ps

module wb_commit (
    input  wb_pkg::ex_wb_t                          wb,
    input  logic [wb_pkg::num_gpr-1:0][31:0]        gpr_cur,
    output wb_pkg::gpr_wr_t [wb_pkg::num_slots-1:0] gpr_wr,
    output wb_pkg::seg_wr_t [wb_pkg::num_slots-1:0] seg_wr,
    output logic                                    eflags_wr_en,
    output logic [wb_pkg::eflags_w-1:0]             eflags_wr_data,
    output wb_pkg::mem_wr_t [wb_pkg::num_slots-1:0] mem_wr,
    output wb_pkg::exc_t                            exc
);

    logic commit_ok;

    // an excepting instruction retires nothing but the exception report
    assign commit_ok = wb.valid && !wb.ie;

    always_comb begin
        wb_pkg::wb_result_t res;
        logic [2:0]         ridx;

        gpr_wr         = '0;
        seg_wr         = '0;
        mem_wr         = '0;
        res            = '0;
        ridx           = '0;
        eflags_wr_en   = commit_ok;
        eflags_wr_data = wb.eflags;

        exc.valid   = wb.valid && wb.ie;
        exc.ie_type = wb.ie_type;
        exc.eip     = wb.eip;

        for (int s = 0; s < wb_pkg::num_slots; s++) begin
            res  = wb.results[s];
            ridx = res.dest.regv.idx;
            if (commit_ok && res.wr) begin
                case (res.kind)
                    wb_pkg::kind_gpr: begin
                        gpr_wr[s].en  = 1'b1;
                        gpr_wr[s].idx = ridx;
                        // partial writes keep the upper bits of the live register
                        case (wb.size)
                            wb_pkg::size_byte:
                                gpr_wr[s].data = {gpr_cur[ridx][31:8], res.data[7:0]};
                            wb_pkg::size_word:
                                gpr_wr[s].data = {gpr_cur[ridx][31:16], res.data[15:0]};
                            default:
                                gpr_wr[s].data = res.data;
                        endcase
                    end
                    wb_pkg::kind_seg: begin
                        seg_wr[s].en   = 1'b1;
                        seg_wr[s].idx  = ridx;
                        seg_wr[s].data = res.data[15:0];
                    end
                    wb_pkg::kind_mem: begin
                        mem_wr[s].en   = 1'b1;
                        mem_wr[s].addr = res.dest.addr;
                        mem_wr[s].data = res.data;
                        case (wb.size)
                            wb_pkg::size_byte: mem_wr[s].be = wb_pkg::be_byte;
                            wb_pkg::size_word: mem_wr[s].be = wb_pkg::be_word;
                            default:           mem_wr[s].be = wb_pkg::be_dword;
                        endcase
                    end
                    default: begin
                    end
                endcase
            end
        end

        // checked here so that all outputs are seen from the same evaluation
        for (int s = 0; s < wb_pkg::num_slots; s++) begin
            if (seg_wr[s].en) begin
                assert (int'(seg_wr[s].idx) < wb_pkg::num_seg)
                    else $error("wb_commit: segment index %0d out of range", seg_wr[s].idx);
            end
            if (exc.valid) begin
                assert (!(gpr_wr[s].en || seg_wr[s].en || mem_wr[s].en))
                    else $error("wb_commit: slot %0d writes during exception", s);
            end
        end
        if (exc.valid) begin
            assert (!eflags_wr_en)
                else $error("wb_commit: flags committed during exception");
        end
    end

endmodule

//--- src/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  wb_pkg::ex_wb_t    wb,
    output wb_pkg::redirect_t redirect
);

    logic resolvable;
    logic dir_wrong;
    logic target_wrong;

    // only retiring branches may redirect fetch
    assign resolvable = wb.valid && !wb.ie && wb.br_valid;

    assign dir_wrong = wb.br_taken != wb.br_pred_taken;

    // a not-taken branch has no target to get wrong
    assign target_wrong = wb.br_taken && (wb.br_pred_target != wb.br_fip);

    assign redirect.valid = resolvable && (dir_wrong || target_wrong);

    // fall-through address when the branch was not taken
    assign redirect.target = wb.br_taken ? wb.br_fip : wb.br_fip_p1;

endmodule

//--- src/arch_reg_file.sv
`timescale 1ns/1ps

module arch_reg_file (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  wb_pkg::gpr_wr_t [wb_pkg::num_slots-1:0] gpr_wr,
    input  wb_pkg::seg_wr_t [wb_pkg::num_slots-1:0] seg_wr,
    input  logic                                    eflags_wr_en,
    input  logic [wb_pkg::eflags_w-1:0]             eflags_wr_data,
    output logic [wb_pkg::num_gpr-1:0][31:0]        gpr_cur,
    input  logic [2:0]                              rd_idx,
    output logic [31:0]                             rd_data,
    input  logic [2:0]                              seg_rd_idx,
    output logic [15:0]                             seg_rd_data,
    output logic [wb_pkg::eflags_w-1:0]             eflags
);

    logic [wb_pkg::num_gpr-1:0][31:0] gpr_q;
    logic [wb_pkg::num_seg-1:0][15:0] seg_q;
    logic [wb_pkg::eflags_w-1:0]      eflags_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpr_q    <= '0;
            seg_q    <= '0;
            eflags_q <= '0;
        end else begin
            // later slots are applied last, so the highest slot wins a conflict
            for (int s = 0; s < wb_pkg::num_slots; s++) begin
                if (gpr_wr[s].en) begin
                    gpr_q[gpr_wr[s].idx] <= gpr_wr[s].data;
                end
                if (seg_wr[s].en && (int'(seg_wr[s].idx) < wb_pkg::num_seg)) begin
                    seg_q[seg_wr[s].idx] <= seg_wr[s].data;
                end
            end
            if (eflags_wr_en) begin
                eflags_q <= eflags_wr_data;
            end
        end
    end

    assign gpr_cur = gpr_q;
    assign rd_data = gpr_q[rd_idx];
    assign eflags  = eflags_q;

    // indices 6 and 7 name no segment register and read as zero
    assign seg_rd_data = (int'(seg_rd_idx) < wb_pkg::num_seg) ? seg_q[seg_rd_idx] : 16'h0;

endmodule

//--- src/wb_stage_top.sv
`timescale 1ns/1ps

module wb_stage_top (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  wb_pkg::ex_wb_t                          ex_in,
    input  logic                                    flush,
    input  logic [2:0]                              rd_idx,
    output logic [31:0]                             rd_data,
    input  logic [2:0]                              seg_rd_idx,
    output logic [15:0]                             seg_rd_data,
    output logic [wb_pkg::eflags_w-1:0]             eflags,
    output wb_pkg::mem_wr_t [wb_pkg::num_slots-1:0] mem_wr,
    output wb_pkg::exc_t                            exc,
    output wb_pkg::redirect_t                       redirect
);

    wb_pkg::ex_wb_t                          wb_rec;
    logic [wb_pkg::num_gpr-1:0][31:0]        gpr_cur;
    wb_pkg::gpr_wr_t [wb_pkg::num_slots-1:0] gpr_wr;
    wb_pkg::seg_wr_t [wb_pkg::num_slots-1:0] seg_wr;
    logic                                    eflags_wr_en;
    logic [wb_pkg::eflags_w-1:0]             eflags_wr_data;

    ex_wb_latch u_latch (
        .clk            (clk),
        .arst_n         (arst_n),
        .ex             (ex_in),
        .flush          (flush),
        .redirect_valid (redirect.valid),
        .wb             (wb_rec)
    );

    wb_commit u_commit (
        .wb             (wb_rec),
        .gpr_cur        (gpr_cur),
        .gpr_wr         (gpr_wr),
        .seg_wr         (seg_wr),
        .eflags_wr_en   (eflags_wr_en),
        .eflags_wr_data (eflags_wr_data),
        .mem_wr         (mem_wr),
        .exc            (exc)
    );

    branch_resolve u_branch (
        .wb       (wb_rec),
        .redirect (redirect)
    );

    arch_reg_file u_regs (
        .clk            (clk),
        .arst_n         (arst_n),
        .gpr_wr         (gpr_wr),
        .seg_wr         (seg_wr),
        .eflags_wr_en   (eflags_wr_en),
        .eflags_wr_data (eflags_wr_data),
        .gpr_cur        (gpr_cur),
        .rd_idx         (rd_idx),
        .rd_data        (rd_data),
        .seg_rd_idx     (seg_rd_idx),
        .seg_rd_data    (seg_rd_data),
        .eflags         (eflags)
    );

    // an excepting record must not also redirect fetch
    a_exc_no_redirect: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(exc.valid && redirect.valid)
    ) else $error("wb_stage_top: exception and redirect in the same cycle");

    // a redirect squashes the next record, so two redirects never come back to back
    a_no_double_redirect: assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect.valid |=> !redirect.valid
    ) else $error("wb_stage_top: redirect on consecutive cycles");

endmodule

//--- dv/wb_stage_tb.sv
`timescale 1ns/1ps

module wb_stage_tb;

    localparam int clk_period = 40;
    localparam int n_gpr      = 300;
    localparam int n_mix      = 300;
    localparam int n_exc      = 200;
    localparam int n_br       = 300;
    localparam int n_flush    = 200;
    localparam int sweep_len  = 9;
    localparam int margin     = 100;
    localparam int total_cycles = 4 + n_gpr + n_mix + n_exc + n_br + n_flush
                                + 6 * sweep_len + margin;

    logic                                    clk;
    logic                                    arst_n;
    wb_pkg::ex_wb_t                          ex_in;
    logic                                    flush;
    logic [2:0]                              rd_idx;
    logic [31:0]                             rd_data;
    logic [2:0]                              seg_rd_idx;
    logic [15:0]                             seg_rd_data;
    logic [wb_pkg::eflags_w-1:0]             eflags;
    wb_pkg::mem_wr_t [wb_pkg::num_slots-1:0] mem_wr;
    wb_pkg::exc_t                            exc;
    wb_pkg::redirect_t                       redirect;

    logic [31:0]                 lfsr;
    logic [31:0]                 m_gpr [wb_pkg::num_gpr];
    logic [15:0]                 m_seg [wb_pkg::num_seg];
    logic [wb_pkg::eflags_w-1:0] m_eflags;
    wb_pkg::ex_wb_t              m_rec;
    string                       cur_test;
    int                          n_checks;
    int                          n_errors;
    int                          checks0;
    int                          errors0;
    int                          n_redirects;

    wb_stage_top DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .ex_in       (ex_in),
        .flush       (flush),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .seg_rd_idx  (seg_rd_idx),
        .seg_rd_data (seg_rd_data),
        .eflags      (eflags),
        .mem_wr      (mem_wr),
        .exc         (exc),
        .redirect    (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(clk_period * total_cycles);
        $display("timeout: the run did not finish within %0d cycles", total_cycles);
        $display("Checks failed");
        $finish;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [2:0] seg_index();
        logic [2:0] v;
        v = 3'(rand_bits(3));
        if (v >= 3'd6) begin
            v = v - 3'd6;
        end
        return v;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH test=%s %s expected=%0h actual=%0h", cur_test, what, exp, act);
        end
    endtask

    function automatic wb_pkg::ex_wb_t make_record(input bit mixed, input bit with_exc,
                                                   input bit with_br);
        wb_pkg::ex_wb_t r;
        logic [1:0]     kind;
        logic [1:0]     sz;
        logic [2:0]     idx;
        logic [31:0]    d;
        r        = '0;
        r.valid  = rand_bits(3) != 32'd0;
        r.eip    = rand_bits(32);
        r.eflags = 18'(rand_bits(18));
        sz = 2'(rand_bits(2));
        if (sz == 2'd3) begin
            sz = 2'd2;
        end
        r.size = wb_pkg::res_size_e'(sz);
        if (with_exc) begin
            r.ie      = rand_bits(1) != 32'd0;
            r.ie_type = 4'(rand_bits(4));
        end
        for (int s = 0; s < wb_pkg::num_slots; s++) begin
            kind = mixed ? 2'(rand_bits(2)) : 2'(wb_pkg::kind_gpr);
            d    = rand_bits(32);
            // a narrow index range makes same-register conflicts frequent
            if (kind == wb_pkg::kind_gpr) begin
                idx    = (rand_bits(1) != 32'd0) ? 3'(rand_bits(2)) : 3'(rand_bits(3));
                d[2:0] = idx;
            end else if (kind == wb_pkg::kind_seg) begin
                d[2:0] = seg_index();
            end
            r.results[s].wr        = rand_bits(3) != 32'd0;
            r.results[s].kind      = wb_pkg::res_kind_e'(kind);
            r.results[s].dest.addr = d;
            r.results[s].data      = rand_bits(32);
        end
        if (with_br) begin
            r.br_valid       = rand_bits(1) != 32'd0;
            r.br_taken       = rand_bits(1) != 32'd0;
            r.br_pred_taken  = rand_bits(1) != 32'd0;
            r.br_fip         = rand_bits(32);
            r.br_pred_target = (rand_bits(1) != 32'd0) ? r.br_fip : rand_bits(32);
            r.br_fip_p1      = rand_bits(32);
        end
        return r;
    endfunction

    function automatic wb_pkg::redirect_t expect_redirect(input wb_pkg::ex_wb_t r);
        wb_pkg::redirect_t e;
        e.valid = r.valid && !r.ie && r.br_valid &&
                  ((r.br_taken != r.br_pred_taken) ||
                   (r.br_taken && (r.br_pred_target != r.br_fip)));
        e.target = r.br_taken ? r.br_fip : r.br_fip_p1;
        return e;
    endfunction

    task automatic compare_outputs();
        wb_pkg::redirect_t e_rd;
        logic              commit_ok;
        logic              exp_en;
        logic [3:0]        exp_be;
        commit_ok = m_rec.valid && !m_rec.ie;
        case (m_rec.size)
            wb_pkg::size_byte: exp_be = 4'b0001;
            wb_pkg::size_word: exp_be = 4'b0011;
            default:           exp_be = 4'b1111;
        endcase
        for (int s = 0; s < wb_pkg::num_slots; s++) begin
            exp_en = commit_ok && m_rec.results[s].wr &&
                     (m_rec.results[s].kind == wb_pkg::kind_mem);
            check_val($sformatf("mem_wr[%0d].en", s), 64'(exp_en), 64'(mem_wr[s].en));
            if (exp_en) begin
                check_val($sformatf("mem_wr[%0d].addr", s),
                          64'(m_rec.results[s].dest.addr), 64'(mem_wr[s].addr));
                check_val($sformatf("mem_wr[%0d].data", s),
                          64'(m_rec.results[s].data), 64'(mem_wr[s].data));
                check_val($sformatf("mem_wr[%0d].be", s), 64'(exp_be), 64'(mem_wr[s].be));
            end
        end
        check_val("exc.valid", 64'(m_rec.valid && m_rec.ie), 64'(exc.valid));
        if (m_rec.valid && m_rec.ie) begin
            check_val("exc.ie_type", 64'(m_rec.ie_type), 64'(exc.ie_type));
            check_val("exc.eip", 64'(m_rec.eip), 64'(exc.eip));
        end
        e_rd = expect_redirect(m_rec);
        check_val("redirect.valid", 64'(e_rd.valid), 64'(redirect.valid));
        if (e_rd.valid) begin
            check_val("redirect.target", 64'(e_rd.target), 64'(redirect.target));
        end
        check_val($sformatf("gpr[%0d]", rd_idx), 64'(m_gpr[rd_idx]), 64'(rd_data));
        check_val($sformatf("seg[%0d]", seg_rd_idx), 64'(m_seg[seg_rd_idx]), 64'(seg_rd_data));
        check_val("eflags", 64'(m_eflags), 64'(eflags));
    endtask

    // partial writes merge with the state from before the record, later slots win
    task automatic apply_model();
        logic [31:0] old [wb_pkg::num_gpr];
        logic [2:0]  idx;
        old = m_gpr;
        if (m_rec.valid && !m_rec.ie) begin
            for (int s = 0; s < wb_pkg::num_slots; s++) begin
                idx = m_rec.results[s].dest.regv.idx;
                if (m_rec.results[s].wr) begin
                    case (m_rec.results[s].kind)
                        wb_pkg::kind_gpr: begin
                            case (m_rec.size)
                                wb_pkg::size_byte:
                                    m_gpr[idx] = {old[idx][31:8], m_rec.results[s].data[7:0]};
                                wb_pkg::size_word:
                                    m_gpr[idx] = {old[idx][31:16], m_rec.results[s].data[15:0]};
                                default:
                                    m_gpr[idx] = m_rec.results[s].data;
                            endcase
                        end
                        wb_pkg::kind_seg: m_seg[idx] = m_rec.results[s].data[15:0];
                        default: begin
                        end
                    endcase
                end
            end
            m_eflags = m_rec.eflags;
        end
    endtask

    // outputs of the current record are checked before the next one is driven
    task automatic run_cycle(input wb_pkg::ex_wb_t rec, input logic fl,
                             input logic [2:0] ri, input logic [2:0] si);
        wb_pkg::redirect_t e_rd;
        @(negedge clk);
        compare_outputs();
        e_rd = expect_redirect(m_rec);
        if (e_rd.valid) begin
            n_redirects++;
        end
        apply_model();
        m_rec = rec;
        if (fl || e_rd.valid) begin
            m_rec.valid = 1'b0;
        end
        ex_in      = rec;
        flush      = fl;
        rd_idx     = ri;
        seg_rd_idx = si;
    endtask

    task automatic read_back_all();
        logic [2:0] ri;
        for (int i = 0; i < sweep_len; i++) begin
            ri = 3'(i);
            run_cycle('0, 1'b0, ri, (ri < 3'd6) ? ri : ri - 3'd6);
        end
    endtask

    task automatic run_random(input int n, input bit mixed, input bit with_exc,
                              input bit with_br, input bit with_flush);
        wb_pkg::ex_wb_t rec;
        logic           fl;
        for (int i = 0; i < n; i++) begin
            rec = make_record(mixed, with_exc, with_br);
            fl  = with_flush && (rand_bits(2) == 32'd0);
            run_cycle(rec, fl, 3'(rand_bits(3)), seg_index());
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        checks0  = n_checks;
        errors0  = n_errors;
    endtask

    task automatic finish_test();
        $display("test %-10s %0d checks, %0d errors", cur_test, n_checks - checks0,
                 n_errors - errors0);
    endtask

    initial begin
        lfsr        = 32'h8099085a;
        arst_n      = 1'b0;
        ex_in       = '0;
        flush       = 1'b0;
        rd_idx      = 3'd0;
        seg_rd_idx  = 3'd0;
        n_checks    = 0;
        n_errors    = 0;
        n_redirects = 0;
        m_rec       = '0;
        m_eflags    = '0;
        for (int i = 0; i < wb_pkg::num_gpr; i++) begin
            m_gpr[i] = '0;
        end
        for (int i = 0; i < wb_pkg::num_seg; i++) begin
            m_seg[i] = '0;
        end

        start_test("reset");
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_outputs();
        arst_n = 1'b1;
        read_back_all();
        finish_test();

        start_test("gpr");
        run_random(n_gpr, 1'b0, 1'b0, 1'b0, 1'b0);
        read_back_all();
        finish_test();

        start_test("seg_mem");
        run_random(n_mix, 1'b1, 1'b0, 1'b0, 1'b0);
        read_back_all();
        finish_test();

        start_test("exception");
        run_random(n_exc, 1'b1, 1'b1, 1'b0, 1'b0);
        read_back_all();
        finish_test();

        start_test("branch");
        run_random(n_br, 1'b1, 1'b0, 1'b1, 1'b0);
        read_back_all();
        finish_test();

        start_test("flush");
        run_random(n_flush, 1'b1, 1'b1, 1'b1, 1'b1);
        read_back_all();
        finish_test();

        $display("total %0d checks, %0d errors, %0d redirects", n_checks, n_errors, n_redirects);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- wb_stage_top.f
src/wb_pkg.sv
src/ex_wb_latch.sv
src/wb_commit.sv
src/branch_resolve.sv
src/arch_reg_file.sv
src/wb_stage_top.sv
dv/wb_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= wb_stage_tb
FILELIST  ?= wb_stage_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
